// File: rtl/gb_bus_defines.svh
`ifndef GB_BUS_DEFINES_SVH
`define GB_BUS_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Address map
//////////////////////////////////////////////////////////////////////

`define BOOT_END        16'h00FF   // Last byte of boot ROM overlay
`define CART_ROM_END    16'h7FFF   // Cartridge ROM ends here

`define CRAM_START      16'hA000   // External cartridge RAM
`define CRAM_END        16'hBFFF

`define WRAM_START      16'hC000   // Work RAM, 8 KB
`define WRAM_END        16'hDFFF

`define ECHO_START      16'hE000   // Mirror of work RAM
`define ECHO_END        16'hFDFF

`define OAM_START       16'hFE00   // Object attribute RAM, page aligned
`define OAM_END         16'hFE9F

// Bus registers
`define REG_DMA         16'hFF46   // OAM DMA source page
`define REG_BOOT        16'hFF50   // Boot overlay disable

//////////////////////////////////////////////////////////////////////
// Memory sizes
//////////////////////////////////////////////////////////////////////

`define WRAM_BANKS      4          // 2 KB each
`define WRAM_BANK_WORDS 2048
`define OAM_WORDS       160
`define DMA_LENGTH      160        // Bytes per OAM transfer

`endif

// File: rtl/gb_bus_pkg.sv
package gb_bus_pkg;

    typedef logic [15:0] addr_t;       // CPU bus address
    typedef logic [7:0]  byte_t;       // Data byte
    typedef logic [10:0] bank_addr_t;  // Word inside one WRAM bank
    typedef logic [1:0]  bank_sel_t;   // WRAM bank number
    typedef logic [7:0]  oam_addr_t;   // OAM byte offset

    // Decoded target of one bus access
    typedef enum logic [2:0] {
        REGION_NONE,       // No read last cycle
        REGION_BOOT,
        REGION_WRAM,       // Includes echo
        REGION_OAM,
        REGION_CART,       // ROM and external RAM
        REGION_REG,        // FF46 / FF50
        REGION_UNMAPPED    // Reads 00
    } region_t;

    typedef enum logic [1:0] {
        DMA_IDLE,
        DMA_READ,          // Fetch source byte
        DMA_WRITE          // Store into OAM
    } dma_state_t;

endpackage

// File: rtl/gb_bus_if.sv
`timescale 1ns/1ns

// Bus as seen after master selection
interface sys_bus_if;
    gb_bus_pkg::addr_t addr;
    gb_bus_pkg::byte_t wdata;
    logic              we;    // One-cycle write strobe
    logic              re;    // One-cycle read strobe

    modport master (output addr, wdata, we, re);
    modport slave  (input  addr, wdata, we, re);
endinterface

// One RAM port, WRAM bank or OAM
interface mem_port_if;
    gb_bus_pkg::bank_addr_t addr;
    gb_bus_pkg::byte_t      wdata;
    logic                   we;
    logic                   re;
    gb_bus_pkg::byte_t      rdata;   // Valid the cycle after re

    modport ctrl  (output addr, wdata, we, re);
    modport mem   (input  addr, wdata, we, re, output rdata);
    modport drain (input  rdata);
endinterface

// File: rtl/dma_engine.sv
`timescale 1ns/1ns
`include "gb_bus_defines.svh"

module dma_engine (
    input  logic              clk,
    input  logic              reset,
    input  gb_bus_pkg::addr_t cpu_addr,
    input  gb_bus_pkg::byte_t cpu_wdata,
    input  logic              cpu_we,
    input  logic              cpu_re,
    input  logic              dma_start,  // Write to FF46 this cycle
    input  gb_bus_pkg::byte_t dma_page,   // Source page, high address byte
    input  gb_bus_pkg::byte_t bus_rdata,  // Read return, one cycle behind
    output logic              dma_busy,
    sys_bus_if.master         bus
);

    gb_bus_pkg::dma_state_t state;
    gb_bus_pkg::oam_addr_t  count;        // Byte being copied
    logic                   last_byte;

    assign last_byte = (count == 8'(`DMA_LENGTH - 1));
    assign dma_busy  = (state != gb_bus_pkg::DMA_IDLE);  // CPU locked out

    //////////////////////////////////////////////////////////////////////
    // Copy sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= gb_bus_pkg::DMA_IDLE;
            count <= '0;
        end else begin
            case (state)
                gb_bus_pkg::DMA_IDLE: begin
                    if (dma_start) begin
                        state <= gb_bus_pkg::DMA_READ;
                        count <= '0;
                    end
                end
                gb_bus_pkg::DMA_READ:  state <= gb_bus_pkg::DMA_WRITE;
                gb_bus_pkg::DMA_WRITE: begin
                    count <= count + 8'd1;
                    // 2 cycles per byte, 320 in total
                    state <= last_byte ? gb_bus_pkg::DMA_IDLE : gb_bus_pkg::DMA_READ;
                end
                default: state <= gb_bus_pkg::DMA_IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Bus master select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        bus.addr  = cpu_addr;    // CPU owns the bus when idle
        bus.wdata = cpu_wdata;
        bus.we    = cpu_we;
        bus.re    = cpu_re;
        case (state)
            gb_bus_pkg::DMA_READ: begin
                bus.addr = {dma_page, count};            // page*256 + k
                bus.we   = 1'b0;
                bus.re   = 1'b1;
            end
            gb_bus_pkg::DMA_WRITE: begin
                bus.addr  = `OAM_START + {8'h00, count};
                bus.wdata = bus_rdata;                   // Byte fetched last cycle
                bus.we    = 1'b1;
                bus.re    = 1'b0;
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/address_decoder.sv
`timescale 1ns/1ns
`include "gb_bus_defines.svh"

module address_decoder (
    input  logic                    clk,
    input  logic                    reset,
    sys_bus_if.slave                bus,
    mem_port_if.ctrl                wram_port [`WRAM_BANKS],
    mem_port_if.ctrl                oam_port,
    output gb_bus_pkg::byte_t       boot_addr,
    output logic                    boot_re,
    output gb_bus_pkg::region_t     read_region,  // Region of last cycle's read
    output gb_bus_pkg::bank_sel_t   read_bank,
    output gb_bus_pkg::byte_t       reg_rdata,
    output logic                    dma_start,
    output gb_bus_pkg::byte_t       dma_page,
    output gb_bus_pkg::addr_t       cart_a,
    output gb_bus_pkg::byte_t       cart_d_out,
    output logic                    cart_wr,
    output logic                    cart_rd,
    output logic                    cart_cs
);

    gb_bus_pkg::region_t   region;
    gb_bus_pkg::addr_t     wram_off;    // Offset into 8 KB of WRAM
    gb_bus_pkg::bank_sel_t bank;
    gb_bus_pkg::byte_t     boot_reg;    // FF50
    logic                  in_cram;

    assign in_cram = (bus.addr >= `CRAM_START) && (bus.addr <= `CRAM_END);

    //////////////////////////////////////////////////////////////////////
    // Region decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (bus.addr <= `BOOT_END && !boot_reg[0])
            region = gb_bus_pkg::REGION_BOOT;     // Overlay wins over cart ROM
        else if (bus.addr <= `CART_ROM_END || in_cram)
            region = gb_bus_pkg::REGION_CART;
        else if (bus.addr >= `WRAM_START && bus.addr <= `ECHO_END)
            region = gb_bus_pkg::REGION_WRAM;     // WRAM plus echo
        else if (bus.addr >= `OAM_START && bus.addr <= `OAM_END)
            region = gb_bus_pkg::REGION_OAM;
        else if (bus.addr == `REG_DMA || bus.addr == `REG_BOOT)
            region = gb_bus_pkg::REGION_REG;
        else
            region = gb_bus_pkg::REGION_UNMAPPED; // VRAM, IO, HRAM etc
    end

    // Echo folds back onto C000
    assign wram_off = bus.addr - ((bus.addr >= `ECHO_START) ? `ECHO_START : `WRAM_START);
    assign bank     = wram_off[12:11];

    for (genvar i = 0; i < `WRAM_BANKS; i++) begin : g_wram
        assign wram_port[i].addr  = wram_off[10:0];
        assign wram_port[i].wdata = bus.wdata;
        assign wram_port[i].we    = bus.we && (region == gb_bus_pkg::REGION_WRAM)
                                    && (bank == gb_bus_pkg::bank_sel_t'(i));
        assign wram_port[i].re    = bus.re && (region == gb_bus_pkg::REGION_WRAM)
                                    && (bank == gb_bus_pkg::bank_sel_t'(i));
    end

    assign oam_port.addr  = {3'b000, bus.addr[7:0]};  // FE00 is page aligned
    assign oam_port.wdata = bus.wdata;
    assign oam_port.we    = bus.we && (region == gb_bus_pkg::REGION_OAM);
    assign oam_port.re    = bus.re && (region == gb_bus_pkg::REGION_OAM);

    assign boot_addr = bus.addr[7:0];
    assign boot_re   = bus.re && (region == gb_bus_pkg::REGION_BOOT);

    // Cartridge pins follow the bus in the same cycle
    assign cart_a     = bus.addr;
    assign cart_d_out = bus.wdata;
    assign cart_wr    = bus.we && (region == gb_bus_pkg::REGION_CART);
    assign cart_rd    = bus.re && (region == gb_bus_pkg::REGION_CART);
    assign cart_cs    = (bus.we || bus.re) && in_cram;

    assign dma_start = bus.we && (bus.addr == `REG_DMA);

    //////////////////////////////////////////////////////////////////////
    // Bus registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            boot_reg    <= '0;                        // Overlay enabled
            dma_page    <= '0;
            read_region <= gb_bus_pkg::REGION_NONE;
        end else begin
            if (bus.we && bus.addr == `REG_BOOT)
                boot_reg <= {bus.wdata[7:1], bus.wdata[0] | boot_reg[0]}; // Bit 0 sticky
            if (dma_start)
                dma_page <= bus.wdata;
            read_region <= bus.re ? region : gb_bus_pkg::REGION_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.re) begin
            read_bank <= bank;
            reg_rdata <= (bus.addr == `REG_DMA) ? dma_page : boot_reg;
        end
    end

endmodule

// File: rtl/ram_bank.sv
`timescale 1ns/1ns

module ram_bank #(
    parameter int words = 2048
) (
    input  logic    clk,
    mem_port_if.mem port
);

    localparam int aw = $clog2(words);     // Index bits actually used

    gb_bus_pkg::byte_t mem [words];
    gb_bus_pkg::byte_t rdata_q;            // Read register

    always_ff @(posedge clk) begin
        if (port.we)
            mem[port.addr[aw-1:0]] <= port.wdata;
        if (port.re)
            rdata_q <= mem[port.addr[aw-1:0]];  // Holds until next read
    end

    assign port.rdata = rdata_q;

endmodule

// File: rtl/boot_rom.sv
`timescale 1ns/1ns

module boot_rom (
    input  logic              clk,
    input  gb_bus_pkg::byte_t addr,
    input  logic              re,
    output gb_bus_pkg::byte_t data
);

    gb_bus_pkg::byte_t rom [256];

    initial $readmemh("rtl/boot_rom.hex", rom);   // 16 bytes per line

    always_ff @(posedge clk) begin
        if (re)
            data <= rom[addr];   // One-cycle read
    end

endmodule

// File: rtl/read_return.sv
`timescale 1ns/1ns
`include "gb_bus_defines.svh"

module read_return (
    input  logic                  clk,
    input  logic                  reset,
    input  gb_bus_pkg::region_t   read_region,
    input  gb_bus_pkg::bank_sel_t read_bank,
    mem_port_if.drain             wram_port [`WRAM_BANKS],
    mem_port_if.drain             oam_port,
    input  gb_bus_pkg::byte_t     boot_data,
    input  gb_bus_pkg::byte_t     reg_rdata,
    input  gb_bus_pkg::byte_t     cart_d_in,
    output gb_bus_pkg::byte_t     rdata
);

    gb_bus_pkg::byte_t wram_rdata [`WRAM_BANKS];
    gb_bus_pkg::byte_t cart_q;      // Cart data at end of strobe cycle
    gb_bus_pkg::byte_t sel_data;
    gb_bus_pkg::byte_t held;        // Last completed read

    for (genvar i = 0; i < `WRAM_BANKS; i++) begin : g_drain
        assign wram_rdata[i] = wram_port[i].rdata;
    end

    // Used only when the previous cycle was a cart read
    always_ff @(posedge clk) begin
        cart_q <= cart_d_in;
    end

    always_comb begin
        case (read_region)
            gb_bus_pkg::REGION_NONE: sel_data = held;   // No read, keep value
            gb_bus_pkg::REGION_BOOT: sel_data = boot_data;
            gb_bus_pkg::REGION_WRAM: sel_data = wram_rdata[read_bank];
            gb_bus_pkg::REGION_OAM:  sel_data = oam_port.rdata;
            gb_bus_pkg::REGION_CART: sel_data = cart_q;
            gb_bus_pkg::REGION_REG:  sel_data = reg_rdata;
            default:                 sel_data = 8'h00;  // Unmapped
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            held <= '0;
        else if (read_region != gb_bus_pkg::REGION_NONE)
            held <= sel_data;
    end

    assign rdata = sel_data;   // Data visible in the cycle after the strobe

endmodule

// File: rtl/gb_bus_top.sv
`timescale 1ns/1ns
`include "gb_bus_defines.svh"

module gb_bus_top (
    input  logic        clk,
    input  logic        reset,
    // CPU side
    input  logic [15:0] cpu_addr,
    input  logic [7:0]  cpu_wdata,
    input  logic        cpu_we,
    input  logic        cpu_re,
    output logic [7:0]  cpu_rdata,
    output logic        dma_busy,     // CPU strobes dropped while high
    // Cartridge pins
    output logic [15:0] cart_a,
    output logic [7:0]  cart_d_out,
    input  logic [7:0]  cart_d_in,
    output logic        cart_wr,
    output logic        cart_rd,
    output logic        cart_cs
);

    sys_bus_if  bus0 ();
    mem_port_if wram_if [`WRAM_BANKS] ();
    mem_port_if oam_if ();

    gb_bus_pkg::byte_t     boot_addr;
    gb_bus_pkg::byte_t     boot_data;
    logic                  boot_re;
    gb_bus_pkg::region_t   read_region;
    gb_bus_pkg::bank_sel_t read_bank;
    gb_bus_pkg::byte_t     reg_rdata;
    logic                  dma_start;
    gb_bus_pkg::byte_t     dma_page;

    //////////////////////////////////////////////////////////////////////
    // Master select and decode
    //////////////////////////////////////////////////////////////////////

    dma_engine dma0 (
        .clk       (clk),
        .reset     (reset),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_we    (cpu_we),
        .cpu_re    (cpu_re),
        .dma_start (dma_start),
        .dma_page  (dma_page),
        .bus_rdata (cpu_rdata),    // DMA reads come back through here
        .dma_busy  (dma_busy),
        .bus       (bus0)
    );

    address_decoder dec0 (
        .clk         (clk),
        .reset       (reset),
        .bus         (bus0),
        .wram_port   (wram_if),
        .oam_port    (oam_if),
        .boot_addr   (boot_addr),
        .boot_re     (boot_re),
        .read_region (read_region),
        .read_bank   (read_bank),
        .reg_rdata   (reg_rdata),
        .dma_start   (dma_start),
        .dma_page    (dma_page),
        .cart_a      (cart_a),
        .cart_d_out  (cart_d_out),
        .cart_wr     (cart_wr),
        .cart_rd     (cart_rd),
        .cart_cs     (cart_cs)
    );

    //////////////////////////////////////////////////////////////////////
    // Memories
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `WRAM_BANKS; i++) begin : g_wram
        ram_bank #(.words(`WRAM_BANK_WORDS)) wram_bank (
            .clk  (clk),
            .port (wram_if[i])
        );
    end

    ram_bank #(.words(`OAM_WORDS)) oam_ram (
        .clk  (clk),
        .port (oam_if)
    );

    boot_rom brom0 (
        .clk  (clk),
        .addr (boot_addr),
        .re   (boot_re),
        .data (boot_data)
    );

    read_return ret0 (
        .clk         (clk),
        .reset       (reset),
        .read_region (read_region),
        .read_bank   (read_bank),
        .wram_port   (wram_if),
        .oam_port    (oam_if),
        .boot_data   (boot_data),
        .reg_rdata   (reg_rdata),
        .cart_d_in   (cart_d_in),
        .rdata       (cpu_rdata)
    );

endmodule

// File: verif/gb_bus_sva.sv
`timescale 1ns/1ns

module gb_bus_sva (
    input logic clk,
    input logic reset,
    input logic dma_busy,
    input logic cart_wr,
    input logic cart_rd,
    input logic cart_cs
);

    //////////////////////////////////////////////////////////////////////
    // Cartridge strobes
    //////////////////////////////////////////////////////////////////////

    // CPU strobes are dropped during the copy, source page is internal
    no_cart_during_dma: assert property (@(posedge clk) disable iff (reset)
        dma_busy |-> (!cart_wr && !cart_rd))
        else $error("cartridge strobe seen while DMA owns the bus");

    cart_strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(cart_wr && cart_rd))
        else $error("cart_wr and cart_rd high in the same cycle");

    //////////////////////////////////////////////////////////////////////
    // Reset state
    //////////////////////////////////////////////////////////////////////

    quiet_after_reset: assert property (@(posedge clk)
        reset |=> (!dma_busy && !cart_wr && !cart_rd && !cart_cs))
        else $error("bus outputs not idle in the cycle after reset");

endmodule

bind gb_bus_top gb_bus_sva sva0 (
    .clk      (clk),
    .reset    (reset),
    .dma_busy (dma_busy),
    .cart_wr  (cart_wr),
    .cart_rd  (cart_rd),
    .cart_cs  (cart_cs)
);

// File: verif/gb_bus_tb.sv
`timescale 1ns/1ns
`include "gb_bus_defines.svh"

module gb_bus_tb;

    typedef enum logic [2:0] {
        OP_WRITE,       // Plain CPU write
        OP_READ,        // CPU read, rdata compared next cycle
        OP_CART_RD,     // Read plus same-cycle pin checks
        OP_CART_WR,
        OP_DMA          // Page write to FF46, lockout timed
    } op_t;

    typedef struct packed {
        op_t               op;
        gb_bus_pkg::addr_t addr;
        gb_bus_pkg::byte_t data;
        gb_bus_pkg::byte_t exp;     // Expected read data
    } step_t;

    logic              clk;
    logic              reset;
    gb_bus_pkg::addr_t cpu_addr;
    gb_bus_pkg::byte_t cpu_wdata;
    logic              cpu_we;
    logic              cpu_re;
    gb_bus_pkg::byte_t cpu_rdata;
    logic              dma_busy;
    gb_bus_pkg::addr_t cart_a;
    gb_bus_pkg::byte_t cart_d_out;
    gb_bus_pkg::byte_t cart_d_in;
    logic              cart_wr;
    logic              cart_rd;
    logic              cart_cs;

    step_t             steps [$];
    gb_bus_pkg::byte_t shadow [65536];   // Expected memory, echo folded
    gb_bus_pkg::byte_t boot_img [256];
    logic              table_ready;

    gb_bus_top dut0 (.*);

    // Cartridge answers with its address low byte scrambled
    assign cart_d_in = cart_a[7:0] ^ 8'hA5;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Failure reporting and compares
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input gb_bus_pkg::byte_t got,
                              input gb_bus_pkg::byte_t exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input gb_bus_pkg::addr_t got,
                              input gb_bus_pkg::addr_t exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Table construction
    //////////////////////////////////////////////////////////////////////

    function automatic gb_bus_pkg::addr_t fold_echo(input gb_bus_pkg::addr_t a);
        if (a >= `ECHO_START && a <= `ECHO_END)
            return a - (`ECHO_START - `WRAM_START);   // E000 lands on C000
        return a;
    endfunction

    function automatic gb_bus_pkg::byte_t cart_reply(input gb_bus_pkg::addr_t a);
        return a[7:0] ^ 8'hA5;
    endfunction

    function automatic gb_bus_pkg::byte_t random_byte();
        return gb_bus_pkg::byte_t'($urandom);
    endfunction

    task automatic push_write(input op_t op, input gb_bus_pkg::addr_t a,
                              input gb_bus_pkg::byte_t d);
        shadow[fold_echo(a)] = d;
        steps.push_back('{op, a, d, 8'h00});
    endtask

    task automatic push_read(input op_t op, input gb_bus_pkg::addr_t a,
                             input gb_bus_pkg::byte_t e);
        steps.push_back('{op, a, 8'h00, e});
    endtask

    task automatic push_dma(input gb_bus_pkg::byte_t page);
        gb_bus_pkg::addr_t src;
        gb_bus_pkg::addr_t dst;
        steps.push_back('{OP_DMA, `REG_DMA, page, 8'h00});
        shadow[`REG_DMA] = page;
        for (int k = 0; k < `DMA_LENGTH; k++) begin
            src = {page, 8'(k)};                      // page*256 + k
            dst = `OAM_START + gb_bus_pkg::addr_t'(k);
            shadow[dst] = shadow[fold_echo(src)];
        end
    endtask

    // One write per bank at a common offset, then every bank read back
    task automatic bank_isolation_pass(input bit descending);
        gb_bus_pkg::addr_t a;
        int                b;
        for (int n = 0; n < `WRAM_BANKS; n++) begin
            b = descending ? `WRAM_BANKS - 1 - n : n;
            a = `WRAM_START + gb_bus_pkg::addr_t'(b) * 16'h0800 + 16'h0010;
            push_write(OP_WRITE, a, random_byte());
        end
        for (int n = 0; n < `WRAM_BANKS; n++) begin
            a = `WRAM_START + gb_bus_pkg::addr_t'(n) * 16'h0800 + 16'h0010;
            push_read(OP_READ, a, shadow[a]);
        end
    endtask

    task automatic build_table();
        gb_bus_pkg::addr_t a;
        foreach (shadow[i])
            shadow[i] = 8'h00;
        // Same offset in every bank so a bank mixup shows
        bank_isolation_pass(1'b0);
        bank_isolation_pass(1'b1);   // Spill into a higher bank shows here
        push_write(OP_WRITE, 16'hE123, random_byte());   // Echo to WRAM
        push_read(OP_READ, 16'hC123, shadow[16'hC123]);
        push_write(OP_WRITE, 16'hC456, random_byte());   // WRAM to echo
        push_read(OP_READ, 16'hE456, shadow[16'hC456]);
        push_write(OP_WRITE, 16'hFDFF, random_byte());   // Top of echo
        push_read(OP_READ, 16'hDDFF, shadow[16'hDDFF]);
        // Boot overlay, then the cartridge beneath it
        push_read(OP_READ, 16'h0000, boot_img[8'h00]);
        push_read(OP_READ, 16'h0042, boot_img[8'h42]);
        push_read(OP_READ, 16'h00FF, boot_img[8'hFF]);
        push_read(OP_READ, `REG_BOOT, 8'h00);
        push_read(OP_READ, `REG_DMA, 8'h00);
        push_write(OP_WRITE, `REG_BOOT, 8'h01);
        push_read(OP_CART_RD, 16'h0000, cart_reply(16'h0000));
        push_read(OP_CART_RD, 16'h00FF, cart_reply(16'h00FF));
        push_read(OP_READ, `REG_BOOT, 8'h01);
        push_read(OP_CART_RD, 16'h4000, cart_reply(16'h4000));
        push_write(OP_CART_WR, 16'hA123, random_byte());
        push_read(OP_CART_RD, 16'hA123, cart_reply(16'hA123));
        // Source page for OAM DMA
        for (int k = 0; k < `DMA_LENGTH; k++)
            push_write(OP_WRITE, 16'hC100 + gb_bus_pkg::addr_t'(k), random_byte());
        push_dma(8'hC1);
        for (int k = 0; k < `OAM_WORDS; k++) begin
            a = `OAM_START + gb_bus_pkg::addr_t'(k);
            push_read(OP_READ, a, shadow[a]);
        end
        push_read(OP_READ, `REG_DMA, 8'hC1);
        push_read(OP_READ, 16'hFF10, 8'h00);             // Unmapped IO
        push_read(OP_READ, 16'hFEA0, 8'h00);             // Past OAM
    endtask

    //////////////////////////////////////////////////////////////////////
    // Step execution
    //////////////////////////////////////////////////////////////////////

    task automatic run_step(input step_t s);
        logic is_read;
        is_read = (s.op == OP_READ) || (s.op == OP_CART_RD);
        @(posedge clk);
        cpu_addr  <= s.addr;
        cpu_wdata <= s.data;
        cpu_we    <= !is_read;
        cpu_re    <= is_read;
        @(negedge clk);                                  // Middle of strobe cycle
        if (s.op == OP_CART_RD || s.op == OP_CART_WR) begin
            check_addr("cart_a", cart_a, s.addr);
            check_level("cart_rd", cart_rd, s.op == OP_CART_RD);
            check_level("cart_wr", cart_wr, s.op == OP_CART_WR);
            check_level("cart_cs", cart_cs, (s.addr >= `CRAM_START) && (s.addr <= `CRAM_END));
        end
        if (s.op == OP_CART_WR)
            check_byte("cart_d_out", cart_d_out, s.data);
        if (s.op == OP_DMA)
            check_level("dma_busy", dma_busy, 1'b0);     // Not yet started
        @(posedge clk);
        cpu_we <= 1'b0;
        cpu_re <= (s.op == OP_DMA);                      // Cart read offered in lockout
        if (s.op == OP_DMA)
            cpu_addr <= 16'h4000;
        if (is_read) begin
            @(negedge clk);
            check_byte("cpu_rdata", cpu_rdata, s.exp);
        end
        // Busy from N+1 through N+320, low again at N+321
        if (s.op == OP_DMA) begin
            for (int i = 1; i <= 2 * `DMA_LENGTH + 1; i++) begin
                @(negedge clk);
                check_level("dma_busy", dma_busy, i <= 2 * `DMA_LENGTH);
                if (i <= 2)
                    check_level("cart_rd", cart_rd, 1'b0);   // CPU strobe lost
                if (i == 2) begin
                    @(posedge clk);
                    cpu_re <= 1'b0;
                end
            end
        end
    endtask

    initial begin
        void'($urandom(32'hf9c51acd));
        reset       = 1'b1;
        cpu_addr    = '0;
        cpu_wdata   = '0;
        cpu_we      = 1'b0;
        cpu_re      = 1'b0;
        table_ready = 1'b0;
        $readmemh("rtl/boot_rom.hex", boot_img);
        build_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        foreach (steps[i])
            run_step(steps[i]);
        $display("TESTS PASSED");
        $finish;
    end

    // Watchdog, budget scales with the table
    initial begin
        wait (table_ready);
        repeat (steps.size() * 4 + 400) @(posedge clk);
        abort_run("Timeout, the stimulus table did not complete in the allowed cycles");
    end

endmodule

// File: gb_bus.f
+incdir+rtl
rtl/gb_bus_pkg.sv
rtl/gb_bus_if.sv
rtl/dma_engine.sv
rtl/address_decoder.sv
rtl/ram_bank.sv
rtl/boot_rom.sv
rtl/read_return.sv
rtl/gb_bus_top.sv
verif/gb_bus_sva.sv
verif/gb_bus_tb.sv

// File: Makefile
# Verilator build and run for the memory bus testbench

VERILATOR ?= verilator
TOP       ?= gb_bus_tb
FILELIST  ?= gb_bus.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR JOBS VFLAGS"

# The simulator exits non-zero on any failure, which fails this target
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/boot_rom.hex
// Each line holds 16 bytes of the boot ROM, line n starting at address n*16
// Columns are consecutive addresses, lowest first
5A 5B 58 59 5E 5F 5C 5D 52 53 50 51 56 57 54 55
4A 4B 48 49 4E 4F 4C 4D 42 43 40 41 46 47 44 45
7A 7B 78 79 7E 7F 7C 7D 72 73 70 71 76 77 74 75
6A 6B 68 69 6E 6F 6C 6D 62 63 60 61 66 67 64 65
1A 1B 18 19 1E 1F 1C 1D 12 13 10 11 16 17 14 15
0A 0B 08 09 0E 0F 0C 0D 02 03 00 01 06 07 04 05
3A 3B 38 39 3E 3F 3C 3D 32 33 30 31 36 37 34 35
2A 2B 28 29 2E 2F 2C 2D 22 23 20 21 26 27 24 25
DA DB D8 D9 DE DF DC DD D2 D3 D0 D1 D6 D7 D4 D5
CA CB C8 C9 CE CF CC CD C2 C3 C0 C1 C6 C7 C4 C5
FA FB F8 F9 FE FF FC FD F2 F3 F0 F1 F6 F7 F4 F5
EA EB E8 E9 EE EF EC ED E2 E3 E0 E1 E6 E7 E4 E5
9A 9B 98 99 9E 9F 9C 9D 92 93 90 91 96 97 94 95
8A 8B 88 89 8E 8F 8C 8D 82 83 80 81 86 87 84 85
BA BB B8 B9 BE BF BC BD B2 B3 B0 B1 B6 B7 B4 B5
AA AB A8 A9 AE AF AC AD A2 A3 A0 A1 A6 A7 A4 A5
